// File: sms_host.f
hw/sms_host_pkg.sv
hw/sms_clock_enables.sv
hw/cart_loader.sv
hw/cheat_code_loader.sv
hw/backup_sync.sv
hw/sms_host_top.sv
sim/tb_sms_host.sv

// File: Bender.yml
package:
  name: sms_host

sources:
  - hw/sms_host_pkg.sv
  - hw/sms_clock_enables.sv
  - hw/cart_loader.sv
  - hw/cheat_code_loader.sv
  - hw/backup_sync.sv
  - hw/sms_host_top.sv
  - target: simulation
    files:
      - sim/tb_sms_host.sv

// File: sim/tb_sms_host.sv
// Directed testbench for the Master System host glue top level.
// Models ROM memory with a random ack delay and the SD block side,
// then runs each behavior as its own task and prints one summary line.

`timescale 1ns/10ps
`default_nettype none

module tb_sms_host;

	import sms_host_pkg::*;

	logic               clk_sys;
	logic               reset;
	dl_bus_t            dl;
	rom_wr_t            rom_wr;
	logic               rom_ack;
	logic               dl_wait;
	logic [CART_AW-1:0] cpu_rom_addr;
	logic [CART_AW-1:0] rom_rd_addr;
	logic               game_gear;
	cheat_fields_t      cheat_code;
	logic               cheat_load;
	logic               cheat_clear;
	logic               img_mounted;
	logic               img_readonly;
	logic [63:0]        img_size;
	logic               nvram_we;
	logic               osd_open;
	logic               bk_load;
	logic               bk_save;
	logic               autosave;
	sd_req_t            sd;
	logic               sd_ack;
	logic               bk_busy;
	logic               bk_pending;
	logic               core_reset;
	ce_t                ce;

	integer      seed = 32'hd7b9dd6a;
	int          errors;
	int          timeouts;
	int          load_pulses;
	int          clear_pulses;
	int          mem_lat;
	logic [7:0]  mem [0:32767];
	logic [31:0] sd_lba_q [$];
	logic        sd_wr_q [$];
	logic        sd_rd_q [$];

	sms_host_top UUT (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.dl           (dl),
		.rom_wr       (rom_wr),
		.rom_ack      (rom_ack),
		.dl_wait      (dl_wait),
		.cpu_rom_addr (cpu_rom_addr),
		.rom_rd_addr  (rom_rd_addr),
		.game_gear    (game_gear),
		.cheat_code   (cheat_code),
		.cheat_load   (cheat_load),
		.cheat_clear  (cheat_clear),
		.img_mounted  (img_mounted),
		.img_readonly (img_readonly),
		.img_size     (img_size),
		.nvram_we     (nvram_we),
		.osd_open     (osd_open),
		.bk_load      (bk_load),
		.bk_save      (bk_save),
		.autosave     (autosave),
		.sd           (sd),
		.sd_ack       (sd_ack),
		.bk_busy      (bk_busy),
		.bk_pending   (bk_pending),
		.core_reset   (core_reset),
		.ce           (ce)
	);

	initial clk_sys = 1'b0;
	always #4 clk_sys = ~clk_sys;

	// ======================================================================
	// Reporting helpers
	// ======================================================================
	task automatic log_mismatch(input string name, input logic [127:0] got,
			input logic [127:0] exp);
		errors++;
		$display("Mismatch %s: got %0h, expected %0h", name, got, exp);
	endtask

	task automatic flag_error(input string what);
		errors++;
		$display("Error: %s", what);
	endtask

	task automatic note_timeout(input string what);
		timeouts++;
		$display("Timeout: %s", what);
	endtask

	// Download data built from every address bit
	function automatic logic [7:0] pattern_byte(input int a);
		logic [31:0] v;
		v = a;
		return v[7:0] ^ v[15:8] ^ v[23:16] ^ 8'h5a;
	endfunction

	// ======================================================================
	// Memory and SD models
	// ======================================================================
	always begin
		@(posedge clk_sys);
		if (!reset && (rom_wr.req !== rom_ack)) begin
			if (rom_wr.addr < 24'd32768) begin
				mem[rom_wr.addr] = rom_wr.data;
			end else begin
				flag_error("ROM write outside the modelled memory");
			end
			mem_lat = ($random(seed) & 3) + 1;
			repeat (mem_lat) @(posedge clk_sys);
			#1 rom_ack = rom_wr.req;
		end
	end

	// Ack two cycles after a request and held for four
	always begin
		@(posedge clk_sys);
		if (!reset && (sd.rd || sd.wr) && !sd_ack) begin
			sd_lba_q.push_back(sd.lba);
			sd_wr_q.push_back(sd.wr);
			sd_rd_q.push_back(sd.rd);
			@(posedge clk_sys);
			#1 sd_ack = 1'b1;
			repeat (4) @(posedge clk_sys);
			#1 sd_ack = 1'b0;
		end
	end

	always @(posedge clk_sys) begin
		if (cheat_load === 1'b1) begin
			load_pulses++;
		end
		if (cheat_clear === 1'b1) begin
			clear_pulses++;
		end
	end

	// ======================================================================
	// Stimulus helpers
	// ======================================================================
	task automatic cart_download(input logic [7:0] idx, input int nbytes,
			input logic mount, input logic exp_gg);
		int t;
		for (int a = 0; a < 32768; a++) begin
			mem[a] = 'x;
		end
		dl.active    = 1'b1;
		dl.index     = idx;
		dl.wr        = 1'b0;
		dl.addr      = '0;
		img_mounted  = mount;
		img_readonly = 1'b0;
		@(posedge clk_sys);
		#1;
		img_mounted = 1'b0;
		for (int a = 0; a < nbytes; a++) begin
			dl.addr = a;
			dl.data = pattern_byte(a);
			dl.wr   = 1'b1;
			@(posedge clk_sys);
			#1;
			dl.wr = 1'b0;
			if (dl_wait !== 1'b1) begin
				log_mismatch("dl_wait", dl_wait, 1'b1);
			end
			t = 0;
			while (dl_wait === 1'b1 && t < 20) begin
				@(posedge clk_sys);
				#1;
				t++;
			end
			if (dl_wait !== 1'b0) begin
				note_timeout("dl_wait stayed high after a ROM write");
				dl.active = 1'b0;
				return;
			end
			if (game_gear !== exp_gg) begin
				log_mismatch("game_gear", game_gear, exp_gg);
			end
		end
		// Address carries the byte count at the end of the download
		dl.addr   = nbytes;
		dl.active = 1'b0;
		@(posedge clk_sys);
		#1;
	endtask

	task automatic wait_busy(input logic level, input int limit, input logic hold_check);
		int t;
		t = 0;
		while (bk_busy !== level && t < limit) begin
			if (hold_check && bk_busy === 1'b1 && core_reset !== 1'b1) begin
				log_mismatch("core_reset", core_reset, 1'b1);
			end
			@(posedge clk_sys);
			#1;
			t++;
		end
		if (bk_busy !== level) begin
			note_timeout($sformatf("bk_busy did not go to %0b", level));
		end
	endtask

	task automatic verify_sectors(input logic exp_wr);
		if (sd_lba_q.size() != 64) begin
			log_mismatch("sector count", sd_lba_q.size(), 64);
		end
		for (int i = 0; i < sd_lba_q.size(); i++) begin
			if (sd_lba_q[i] !== i) begin
				log_mismatch("sd.lba", sd_lba_q[i], i);
			end
			if (sd_wr_q[i] !== exp_wr) begin
				log_mismatch("sd.wr", sd_wr_q[i], exp_wr);
			end
			if (sd_rd_q[i] !== !exp_wr) begin
				log_mismatch("sd.rd", sd_rd_q[i], !exp_wr);
			end
		end
	endtask

	// ======================================================================
	// Tests
	// ======================================================================
	task automatic count_clock_enables();
		int n_cpu = 0;
		int n_vdp = 0;
		int n_pix = 0;
		int n_sp  = 0;
		@(posedge clk_sys);
		#1;
		if (ce !== 4'b0) begin
			log_mismatch("ce", ce, 4'b0);
		end
		for (int i = 0; i < 300; i++) begin
			@(posedge clk_sys);
			#1;
			n_cpu += ce.cpu;
			n_vdp += ce.vdp;
			n_pix += ce.pix;
			n_sp  += ce.sp;
		end
		if (n_vdp != 60) log_mismatch("ce.vdp count", n_vdp, 60);
		if (n_pix != 30) log_mismatch("ce.pix count", n_pix, 30);
		if (n_cpu != 20) log_mismatch("ce.cpu count", n_cpu, 20);
		if (n_sp != 150) log_mismatch("ce.sp count", n_sp, 150);
	endtask

	task automatic load_cartridges();
		cart_download(8'h00, 1024, 1'b0, 1'b0);
		for (int a = 0; a < 1024; a++) begin
			if (mem[a] !== pattern_byte(a)) begin
				log_mismatch($sformatf("mem[%0h]", a), mem[a], pattern_byte(a));
			end
		end
		// Game Gear image
		cart_download(8'h02, 16, 1'b0, 1'b1);
		if (game_gear !== 1'b1) begin
			log_mismatch("game_gear", game_gear, 1'b1);
		end
	endtask

	task automatic map_rom_addresses();
		logic [CART_AW-1:0] a;
		logic [CART_AW-1:0] exp;
		cart_download(8'h00, 16384, 1'b0, 1'b0);
		for (int i = 0; i < 8; i++) begin
			@(posedge clk_sys);
			#1;
			a            = $random(seed);
			cpu_rom_addr = a;
			exp          = a & 22'h3fff;
			#1;
			if (rom_rd_addr !== exp) log_mismatch("rom_rd_addr", rom_rd_addr, exp);
		end
		// Same size plus a 512-byte copier header
		cart_download(8'h00, 16896, 1'b0, 1'b0);
		for (int i = 0; i < 8; i++) begin
			@(posedge clk_sys);
			#1;
			a            = $random(seed);
			cpu_rom_addr = a;
			exp          = (a + 22'd512) & 22'h3fff;
			#1;
			if (rom_rd_addr !== exp) log_mismatch("rom_rd_addr", rom_rd_addr, exp);
		end
	endtask

	task automatic build_cheat_record();
		logic [3:0] nib;
		load_pulses  = 0;
		clear_pulses = 0;
		dl.active = 1'b1;
		dl.index  = CODE_INDEX;
		dl.wr     = 1'b0;
		@(posedge clk_sys);
		#1;
		for (int k = 0; k < 16; k++) begin
			nib     = k;
			dl.addr = k;
			dl.data = {nib, ~nib};
			dl.wr   = 1'b1;
			@(posedge clk_sys);
			#1;
		end
		dl.wr     = 1'b0;
		dl.active = 1'b0;
		repeat (3) @(posedge clk_sys);
		#1;
		// Each field is little endian over its four bytes
		if (cheat_code.flags !== 32'h3c2d1e0f) begin
			log_mismatch("flags", cheat_code.flags, 32'h3c2d1e0f);
		end
		if (cheat_code.address !== 32'h78695a4b) begin
			log_mismatch("address", cheat_code.address, 32'h78695a4b);
		end
		if (cheat_code.compare !== 32'hb4a59687) begin
			log_mismatch("compare", cheat_code.compare, 32'hb4a59687);
		end
		if (cheat_code.replace !== 32'hf0e1d2c3) begin
			log_mismatch("replace", cheat_code.replace, 32'hf0e1d2c3);
		end
		if (load_pulses != 1) log_mismatch("cheat_load pulses", load_pulses, 1);
		if (clear_pulses != 1) log_mismatch("cheat_clear pulses", clear_pulses, 1);
	endtask

	task automatic save_backup();
		img_size = '0;
		cart_download(8'h00, 16, 1'b1, 1'b0);
		if (bk_pending !== 1'b0) log_mismatch("bk_pending", bk_pending, 1'b0);
		nvram_we = 1'b1;
		@(posedge clk_sys);
		#1;
		nvram_we = 1'b0;
		if (bk_pending !== 1'b1) log_mismatch("bk_pending", bk_pending, 1'b1);
		sd_lba_q.delete();
		sd_wr_q.delete();
		sd_rd_q.delete();
		// Menu opens with autosave on
		osd_open = 1'b1;
		autosave = 1'b1;
		wait_busy(1'b1, 10, 1'b0);
		wait_busy(1'b0, 2000, 1'b0);
		osd_open = 1'b0;
		autosave = 1'b0;
		verify_sectors(1'b1);
		if (bk_pending !== 1'b0) log_mismatch("bk_pending", bk_pending, 1'b0);
	endtask

	task automatic restore_backup();
		img_size = 64'h2000;
		sd_lba_q.delete();
		sd_wr_q.delete();
		sd_rd_q.delete();
		cart_download(8'h00, 16, 1'b1, 1'b0);
		wait_busy(1'b1, 10, 1'b0);
		if (core_reset !== 1'b1) log_mismatch("core_reset", core_reset, 1'b1);
		wait_busy(1'b0, 2000, 1'b1);
		verify_sectors(1'b0);
		if (core_reset !== 1'b0) log_mismatch("core_reset", core_reset, 1'b0);
		img_size = '0;
	endtask

	initial begin
		errors       = 0;
		timeouts     = 0;
		load_pulses  = 0;
		clear_pulses = 0;
		reset        = 1'b1;
		dl           = '0;
		rom_ack      = 1'b0;
		cpu_rom_addr = '0;
		img_mounted  = 1'b0;
		img_readonly = 1'b0;
		img_size     = '0;
		nvram_we     = 1'b0;
		osd_open     = 1'b0;
		bk_load      = 1'b0;
		bk_save      = 1'b0;
		autosave     = 1'b0;
		sd_ack       = 1'b0;
		repeat (2) @(posedge clk_sys);
		#1 reset = 1'b0;

		count_clock_enables();
		load_cartridges();
		map_rom_addresses();
		build_cheat_record();
		save_backup();
		restore_backup();

		repeat (4) @(posedge clk_sys);
		$display("Finished with %0d errors and %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: hw/sms_host_top.sv
// Top level of the Master System host glue: clock enables, cartridge
// and cheat loading, and backup RAM sync around an external core.

`timescale 1ns/10ps
`default_nettype none

module sms_host_top (
	input  wire                             clk_sys,
	input  wire                             reset,

	// Download port and ROM memory
	input  wire sms_host_pkg::dl_bus_t      dl,
	output sms_host_pkg::rom_wr_t           rom_wr,
	input  wire                             rom_ack,
	output logic                            dl_wait,
	input  wire [sms_host_pkg::CART_AW-1:0] cpu_rom_addr,
	output logic [sms_host_pkg::CART_AW-1:0] rom_rd_addr,
	output logic                            game_gear,

	// Cheats
	output sms_host_pkg::cheat_fields_t     cheat_code,
	output logic                            cheat_load,
	output logic                            cheat_clear,

	// Backup RAM and SD block port
	input  wire                             img_mounted,
	input  wire                             img_readonly,
	input  wire [63:0]                      img_size,
	input  wire                             nvram_we,
	input  wire                             osd_open,
	input  wire                             bk_load,
	input  wire                             bk_save,
	input  wire                             autosave,
	output sms_host_pkg::sd_req_t           sd,
	input  wire                             sd_ack,
	output logic                            bk_busy,
	output logic                            bk_pending,
	output logic                            core_reset,

	output sms_host_pkg::ce_t               ce
);

	logic cart_active;

	sms_clock_enables u_clock_enables (
		.clk_sys (clk_sys),
		.reset   (reset),
		.ce      (ce)
	);

	cart_loader u_cart_loader (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.dl           (dl),
		.rom_wr       (rom_wr),
		.rom_ack      (rom_ack),
		.dl_wait      (dl_wait),
		.cart_active  (cart_active),
		.game_gear    (game_gear),
		.cpu_rom_addr (cpu_rom_addr),
		.rom_rd_addr  (rom_rd_addr)
	);

	cheat_code_loader u_cheat_code_loader (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.dl          (dl),
		.code        (cheat_code),
		.code_load   (cheat_load),
		.cheat_clear (cheat_clear)
	);

	// Backup restore keeps the core held until its sectors are in
	backup_sync u_backup_sync (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.cart_active  (cart_active),
		.img_mounted  (img_mounted),
		.img_readonly (img_readonly),
		.img_size     (img_size),
		.nvram_we     (nvram_we),
		.osd_open     (osd_open),
		.bk_load      (bk_load),
		.bk_save      (bk_save),
		.autosave     (autosave),
		.sd           (sd),
		.sd_ack       (sd_ack),
		.bk_busy      (bk_busy),
		.bk_loading   (),
		.bk_pending   (bk_pending),
		.core_reset   (core_reset)
	);

endmodule

`default_nettype wire

// File: hw/backup_sync.sv
// Backup RAM save and restore over the SD block port, 64 sectors per run.
// Tracks the enable and pending flags, handles autosave on menu open,
// and holds the core in reset while a cartridge or backup loads.

`timescale 1ns/10ps
`default_nettype none

module backup_sync (
	input  wire                    clk_sys,
	input  wire                    reset,
	input  wire                    cart_active,
	input  wire                    img_mounted,
	input  wire                    img_readonly,
	input  wire [63:0]             img_size,
	input  wire                    nvram_we,
	input  wire                    osd_open,
	input  wire                    bk_load,
	input  wire                    bk_save,
	input  wire                    autosave,
	output sms_host_pkg::sd_req_t  sd,
	input  wire                    sd_ack,
	output logic                   bk_busy,
	output logic                   bk_loading,
	output logic                   bk_pending,
	output logic                   core_reset
);

	import sms_host_pkg::*;

	logic old_active;
	logic old_load;
	logic old_save;
	logic old_ack;
	logic bk_ena;
	logic load_req;
	logic save_req;
	logic start_load;
	logic start_save;

	assign load_req = bk_load && bk_ena;
	assign save_req = (bk_save || (bk_pending && osd_open && autosave)) && bk_ena;

	// Explicit load, or restore once the cartridge is in
	assign start_load = (load_req && !old_load) ||
		(old_active && !cart_active && (|img_size) && bk_ena);
	assign start_save = save_req && !old_save;

	assign core_reset = reset || cart_active || bk_loading;

	// ======================================================================
	// Enable and pending flags
	// ======================================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_active <= 1'b0;
			old_load   <= 1'b0;
			old_save   <= 1'b0;
			old_ack    <= 1'b0;
			bk_ena     <= 1'b0;
			bk_pending <= 1'b0;
		end else begin
			old_active <= cart_active;
			old_load   <= load_req;
			old_save   <= save_req;
			old_ack    <= sd_ack;

			// Save image gets mounted while the cartridge downloads
			if (cart_active && !old_active) begin
				bk_ena <= 1'b0;
			end
			if (cart_active && img_mounted && !img_readonly) begin
				bk_ena <= 1'b1;
			end

			if (bk_ena && !osd_open && nvram_we) begin
				bk_pending <= 1'b1;
			end else if (bk_busy) begin
				bk_pending <= 1'b0;
			end
		end
	end

	// ======================================================================
	// Sector sequencer
	// ======================================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			sd.rd      <= 1'b0;
			sd.wr      <= 1'b0;
			bk_busy    <= 1'b0;
			bk_loading <= 1'b0;
		end else begin
			// Host has taken the request
			if (sd_ack && !old_ack) begin
				sd.rd <= 1'b0;
				sd.wr <= 1'b0;
			end

			if (!bk_busy) begin
				if (start_load || start_save) begin
					bk_busy    <= 1'b1;
					bk_loading <= start_load;
					sd.lba     <= '0;
					sd.rd      <= start_load;
					sd.wr      <= !start_load;
				end
			end else if (old_ack && !sd_ack) begin
				// Sector done
				if (sd.lba == 32'(BK_SECTORS - 1)) begin
					bk_busy    <= 1'b0;
					bk_loading <= 1'b0;
				end else begin
					sd.lba <= sd.lba + 1'b1;
					sd.rd  <= bk_loading;
					sd.wr  <= !bk_loading;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: hw/cheat_code_loader.sv
// Builds 16-byte cheat records from the download port into code words.
// code_load pulses once per completed record, cheat_clear on address 0.

`timescale 1ns/10ps
`default_nettype none

module cheat_code_loader (
	input  wire                          clk_sys,
	input  wire                          reset,
	input  wire sms_host_pkg::dl_bus_t   dl,
	output sms_host_pkg::cheat_fields_t  code,
	output logic                         code_load,
	output logic                         cheat_clear
);

	import sms_host_pkg::*;

	logic       code_wr;
	logic [3:0] offset;
	cheat_rec_u rec;

	assign code_wr = dl.active && (dl.index == CODE_INDEX) && dl.wr;
	assign offset  = dl.addr[3:0];

	// Record bytes, filled in download order
	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			rec.bytes[offset] <= dl.data;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			code_load   <= 1'b0;
			cheat_clear <= 1'b0;
		end else begin
			// Last byte of a record
			code_load   <= code_wr && (offset == 4'hf);
			// Any new download starting from zero wipes the cheat table
			cheat_clear <= dl.active && dl.wr && (dl.addr == '0);
		end
	end

	assign code = rec.fields;

endmodule

`default_nettype wire

// File: hw/cart_loader.sv
// Writes downloaded cartridge bytes to ROM memory over a toggle req/ack,
// learns the image size masks and maps CPU ROM addresses into the image.
// dl_wait stalls the host until memory has taken each byte.

`timescale 1ns/10ps
`default_nettype none

module cart_loader (
	input  wire                          clk_sys,
	input  wire                          reset,
	input  wire sms_host_pkg::dl_bus_t   dl,
	output sms_host_pkg::rom_wr_t        rom_wr,
	input  wire                          rom_ack,
	output logic                         dl_wait,
	output logic                         cart_active,
	output logic                         game_gear,
	input  wire [sms_host_pkg::CART_AW-1:0] cpu_rom_addr,
	output logic [sms_host_pkg::CART_AW-1:0] rom_rd_addr
);

	import sms_host_pkg::*;

	logic              old_active;
	logic              cart_wr;
	logic              req;
	logic [ROM_AW-1:0] wr_addr;
	logic [7:0]        wr_data;
	logic [CART_AW-1:0] mask;
	logic [CART_AW-1:0] mask_hdr;
	logic              hdr;

	assign cart_active = dl.active && (dl.index != CODE_INDEX);
	assign cart_wr     = dl.wr && cart_active;

	// ======================================================================
	// Download writer
	// ======================================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_active <= 1'b0;
			dl_wait    <= 1'b0;
			req        <= 1'b0;
		end else begin
			old_active <= cart_active;
			if (cart_active && !old_active) begin
				wr_addr <= '0;
			end else if (cart_wr) begin
				dl_wait <= 1'b1;
				req     <= ~req;
			end else if (dl_wait && (req == rom_ack)) begin
				// Memory took the byte
				dl_wait <= 1'b0;
				wr_addr <= wr_addr + 1'b1;
			end
		end
	end

	// Byte held until the ack comes back
	always_ff @(posedge clk_sys) begin
		if (cart_wr) begin
			wr_data <= dl.data;
		end
	end

	always_comb begin
		rom_wr.req  = req;
		rom_wr.addr = wr_addr;
		rom_wr.data = wr_data;
	end

	// ======================================================================
	// Size masks
	// ======================================================================
	always_ff @(posedge clk_sys) begin
		if (cart_wr) begin
			mask     <= mask | dl.addr[CART_AW-1:0];
			mask_hdr <= mask_hdr | (dl.addr[CART_AW-1:0] - CART_AW'(HDR_OFFSET));
			if (dl.addr == '0) begin
				mask <= '0;
			end
			if (dl.addr == DL_AW'(HDR_OFFSET)) begin
				mask_hdr <= '0;
			end
		end
	end

	// dl.addr holds the byte count when the download ends,
	// so bit 9 set means a copier header is present
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			hdr       <= 1'b0;
			game_gear <= 1'b0;
		end else begin
			if (cart_wr) begin
				game_gear <= (dl.index[4:0] == GG_INDEX);
			end
			if (old_active && !cart_active) begin
				hdr <= dl.addr[HDR_BIT];
			end
		end
	end

	// CPU address into the image, skipping the header if present
	always_comb begin
		if (hdr) begin
			rom_rd_addr = (cpu_rom_addr + CART_AW'(HDR_OFFSET)) & mask_hdr;
		end else begin
			rom_rd_addr = cpu_rom_addr & mask;
		end
	end

endmodule

`default_nettype wire

// File: hw/sms_clock_enables.sv
// Divides clk_sys into the CPU, VDP, pixel and sprite clock enables.
// A 30-phase counter; every enable is registered.

`timescale 1ns/10ps
`default_nettype none

module sms_clock_enables (
	input  wire               clk_sys,
	input  wire               reset,
	output sms_host_pkg::ce_t ce
);

	import sms_host_pkg::*;

	logic [CE_CNT_W-1:0] phase;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			phase <= '0;
			ce    <= '0;
		end else begin
			if (phase == CE_CNT_W'(CE_PERIOD - 1)) begin
				phase <= '0;
			end else begin
				phase <= phase + 1'b1;
			end

			// Sprite enable on every odd phase
			ce.sp  <= phase[0];
			ce.vdp <= 1'b0;
			ce.pix <= 1'b0;
			ce.cpu <= 1'b0;

			// VDP every 5, pixel every 10, CPU every 15
			case (phase)
				4, 14: begin
					ce.vdp <= 1'b1;
				end
				9: begin
					ce.vdp <= 1'b1;
					ce.pix <= 1'b1;
					ce.cpu <= 1'b1;
				end
				19, 29: begin
					ce.vdp <= 1'b1;
					ce.pix <= 1'b1;
				end
				24: begin
					ce.vdp <= 1'b1;
					ce.cpu <= 1'b1;
				end
				default: begin
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: hw/sms_host_pkg.sv
// Shared constants and bus types for the Master System host glue.
// Modules pull these in by wildcard import; ports use scoped names.

`default_nettype none

package sms_host_pkg;

	// ======================================================================
	// Sizes and indices
	// ======================================================================
	localparam int ROM_AW     = 24;
	localparam int CART_AW    = 22;
	localparam int DL_AW      = 25;
	localparam int HDR_OFFSET = 512;
	localparam int HDR_BIT    = $clog2(HDR_OFFSET);
	localparam int CE_PERIOD  = 30;
	localparam int CE_CNT_W   = $clog2(CE_PERIOD);
	localparam int BK_SECTORS = 64;

	localparam logic [7:0] CODE_INDEX = 8'hff;
	// Low five bits of the download index for Game Gear images
	localparam logic [4:0] GG_INDEX = 5'd2;

	// ======================================================================
	// Bus bundles
	// ======================================================================

	// Host download port
	typedef struct packed {
		logic             wr;
		logic [DL_AW-1:0] addr;
		logic [7:0]       data;
		logic             active;
		logic [7:0]       index;
	} dl_bus_t;

	// ROM write request with a toggling req
	typedef struct packed {
		logic              req;
		logic [ROM_AW-1:0] addr;
		logic [7:0]        data;
	} rom_wr_t;

	// SD block request
	typedef struct packed {
		logic [31:0] lba;
		logic        rd;
		logic        wr;
	} sd_req_t;

	// Cheat record fields declared high to low so that union byte k
	// is download offset k and flags sit in bytes 0..3
	typedef struct packed {
		logic [31:0] replace;
		logic [31:0] compare;
		logic [31:0] address;
		logic [31:0] flags;
	} cheat_fields_t;

	typedef union packed {
		cheat_fields_t    fields;
		logic [15:0][7:0] bytes;
	} cheat_rec_u;

	// Clock enable bundle
	typedef struct packed {
		logic cpu;
		logic vdp;
		logic pix;
		logic sp;
	} ce_t;

endpackage

`default_nettype wire
